// File: Bender.yml
package:
  name: mem_req_queue

sources:
  - include_dirs:
      - common
    files:
      - common/memq_pkg.sv
      - mem_req_queue/req_align.sv
      - mem_req_queue/load_forward.sv
      - mem_req_queue/mem_req_queue.sv
      - verilog/mem_drain.sv
      - verilog/mem_req_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - bench/mem_req_tb.sv

// File: bench/mem_req_tb.sv
// Self-checking testbench that runs seeded random two-port traffic against a queue model
`include "memq_config.svh"

module mem_req_tb;
	import memq_pkg::*;

	localparam int AW = `MEMQ_AWID;
	localparam int DEPTH = `MEMQ_DEPTH;
	localparam int NT = `MEMQ_NTHREADS;
	localparam int PERIOD = 10;
	localparam int NREQ = 3000;
	// Traffic goes to four doublewords above this base, so address bits [4:3] pick the word
	localparam logic [AW-1:0] BASE = AW'('h4000);

	logic clk, rst;
	logic wr0, wr1, nc0, nc1, wr_ack0, wr_ack1, found0, found1;
	memq_func_t func0, func1;
	memq_size_t sz0, sz1;
	logic [AW-1:0] adr0, adr1, bus_adr;
	logic [63:0] dat0, dat1, fwd_dat0, fwd_dat1, bus_dat, bus_rdat, ld_dat;
	logic [1:0] thread0, thread1, ld_thread;
	logic [NT-1:0] rollback;
	logic empty, full, bus_req, bus_we, bus_ack, ld_done;
	logic [7:0] bus_sel;

	// Bus memory and the reference copy of the queue
	logic [63:0] mem [4];
	memq_entry_t q[$];

	integer seed = 94;
	int err_val, err_proto, n_issued, n_acked, lat;
	logic exp_ack0, exp_ack1, ld_pend, start_pend, req_prev;
	logic [63:0] ld_exp;
	logic [1:0] ld_thr;

	mem_req_top dut0 (.*);

	always #(PERIOD / 2) clk = ~clk;

	// ============================================================
	// Reference rules
	// ============================================================

	// Lanes touched by an access of the given size at the given offset
	function automatic logic [7:0] lane_select(memq_size_t s, logic [2:0] off);
		logic [7:0] m;
		for (int b = 0; b < 8; b++)
			m[b] = (b >= int'(off)) && (b < int'(off) + (1 << int'(s)));
		return m;
	endfunction

	// Store data arrives right-justified and is placed starting at its offset lane
	function automatic memq_data_u align_data(logic [63:0] d, logic [2:0] off);
		memq_data_u r;
		for (int b = 0; b < 8; b++)
			r.lane[b] = (b >= int'(off)) ? d[8 * (b - int'(off)) +: 8] : 8'h00;
		return r;
	endfunction

	// Picks the load's bytes out of a doubleword and fills the upper bytes
	function automatic logic [63:0] shift_extend(memq_data_u w, logic [2:0] off, memq_size_t s,
		memq_func_t f);
		logic [63:0] r;
		logic sgn;
		int n;
		n = 1 << int'(s);
		r = '0;
		for (int b = 0; b < n; b++)
			r[8 * b +: 8] = w.lane[int'(off) + b];
		sgn = (f == MQ_LOAD) && r[8 * n - 1];
		for (int b = n; b < 8; b++)
			r[8 * b +: 8] = {8{sgn}};
		return r;
	endfunction

	// Youngest live cacheable store to the doubleword has to hold every byte of the load
	function automatic logic forward_hit(memq_func_t f, memq_size_t s, logic [AW-1:0] a,
		logic n, output logic [63:0] d);
		int y;
		logic [7:0] m;
		y = -1;
		d = '0;
		for (int i = 0; i < q.size(); i++)
			if (q[i].v && q[i].func == MQ_STORE && !q[i].nc && q[i].adr[AW-1:3] == a[AW-1:3])
				y = i;
		m = lane_select(s, a[2:0]);
		if (y < 0 || f == MQ_STORE || n || (q[y].sel & m) != m)
			return 1'b0;
		d = shift_extend(q[y].dat, a[2:0], s, f);
		return 1'b1;
	endfunction

	// The head may already be on the bus, so only a second or later entry takes a merge
	// An entry that this edge rolls back takes no merge either
	function automatic logic merge_ok(memq_func_t f, logic [AW-1:0] a, logic [1:0] t, logic n);
		memq_entry_t y;
		if (q.size() < 2)
			return 1'b0;
		y = q[$];
		return y.v && y.func == MQ_STORE && !y.nc && !rollback[y.thread] && f == MQ_STORE &&
			!n && t == y.thread && a[AW-1:3] == y.adr[AW-1:3];
	endfunction

	function automatic memq_entry_t make_entry(memq_func_t f, memq_size_t s, logic [AW-1:0] a,
		logic [63:0] d, logic [1:0] t, logic n);
		memq_entry_t e;
		e.func = f;
		e.sz = s;
		e.adr = a;
		e.sel = lane_select(s, a[2:0]);
		e.dat = align_data(d, a[2:0]);
		e.thread = t;
		e.nc = n;
		e.v = 1'b1;
		return e;
	endfunction

	// ============================================================
	// Compare tasks
	// ============================================================

	task automatic report_protocol(input string msg);
		err_proto++;
		$display("%0t: %s", $time, msg);
	endtask

	// Load data on the bus is a leftover of the request and only store data counts
	task automatic check_bus(input memq_entry_t e, input logic we, input logic [AW-1:0] a,
		input logic [7:0] sel, input logic [63:0] d);
		if (we !== (e.func == MQ_STORE) || a !== e.adr || sel !== e.sel ||
			(we && d !== e.dat.word)) begin
			err_val++;
			$display("[FAIL] %0t bus we=%b adr=%h sel=%h dat=%h, expected %b %h %h %h",
				$time, we, a, sel, d, e.func == MQ_STORE, e.adr, e.sel, e.dat.word);
		end
	endtask

	task automatic check_fwd(input int p, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			err_val++;
			$display("[FAIL] %0t port %0d forwarded %h, expected %h", $time, p, got, exp);
		end
	endtask

	task automatic check_load(input logic [63:0] got, input logic [63:0] exp,
		input logic [1:0] tgot, input logic [1:0] texp);
		if (got !== exp || tgot !== texp) begin
			err_val++;
			$display("[FAIL] %0t load result %h thread %0d, expected %h thread %0d",
				$time, got, tgot, exp, texp);
		end
	endtask

	task automatic check_ack(input int p, input logic got, input logic exp);
		if (got === 1'b1 && !exp)
			report_protocol($sformatf("port %0d acknowledged a request that had to wait", p));
		else if (got !== 1'b1 && exp)
			report_protocol($sformatf("port %0d request was not acknowledged", p));
	endtask

	task automatic random_request(output memq_func_t f, output memq_size_t s,
		output logic [AW-1:0] a, output logic [63:0] d, output logic [1:0] t, output logic n);
		logic [31:0] r;
		r = $random(seed);
		case (r[1:0])
		2'd0: f = MQ_LOAD;
		2'd1: f = MQ_LOADZ;
		default: f = MQ_STORE;
		endcase
		s = memq_size_t'(r[3:2]);
		// The offset is rounded down to the size so the request stays in one doubleword
		a = BASE | AW'({r[5:4], r[8:6] & (3'b111 << r[3:2])});
		// Thread zero is favoured to make same-thread store merges common
		t = r[9] ? 2'd0 : r[11:10];
		n = (r[14:12] == 3'b000);
		d = {$random(seed), $random(seed)};
	endtask

	// ============================================================
	// Model step, bus memory and stimulus
	// ============================================================

	// Everything here reads the values of the cycle that ends at this edge
	always @(posedge clk) begin : step
		logic req0, req1, hit0, hit1, mrg0, mrg1, acc0, acc1, ack0, ack1, room, pop_m, n;
		logic [63:0] fd0, fd1, d;
		logic [AW-1:0] a;
		logic [31:0] r;
		logic [1:0] t;
		memq_func_t f;
		memq_size_t s;
		memq_entry_t e;
		if (!rst) begin
			// Results that were promised one cycle ago
			check_ack(0, wr_ack0, exp_ack0);
			check_ack(1, wr_ack1, exp_ack1);
			if (ld_pend && ld_done !== 1'b1)
				report_protocol("load result missing one cycle after the bus acknowledge");
			else if (ld_pend)
				check_load(ld_dat, ld_exp, ld_thread, ld_thr);
			else if (ld_done === 1'b1)
				report_protocol("load result without a load on the bus");
			if (start_pend && bus_req !== 1'b1)
				report_protocol("drain did not start a bus request for a live head");
			else if (bus_req === 1'b1 && !req_prev && !start_pend)
				report_protocol("unexpected bus transaction");
			if (full !== (q.size() == DEPTH) || empty !== (q.size() == 0))
				report_protocol("full or empty disagrees with the queue fill level");
			ld_pend = 1'b0;

			// Forwarding in the current cycle
			req0 = wr0 && !wr_ack0;
			req1 = wr1 && !wr_ack1;
			hit0 = forward_hit(func0, sz0, adr0, nc0, fd0);
			hit1 = forward_hit(func1, sz1, adr1, nc1, fd1);
			if (found0 !== (req0 && hit0))
				report_protocol($sformatf("port 0 found is %b, expected %b", found0,
					req0 && hit0));
			else if (found0)
				check_fwd(0, fwd_dat0, fd0);
			if (found1 !== (req1 && hit1))
				report_protocol($sformatf("port 1 found is %b, expected %b", found1,
					req1 && hit1));
			else if (found1)
				check_fwd(1, fwd_dat1, fd1);

			// A finished bus cycle or a dead head leaves the queue at this edge
			pop_m = bus_req ? bus_ack : (q.size() > 0 && !q[0].v);
			if (bus_req && bus_ack) begin
				if (q.size() == 0) begin
					report_protocol("bus transaction with nothing queued");
				end else begin
					e = q[0];
					check_bus(e, bus_we, bus_adr, bus_sel, bus_dat);
					if (e.func == MQ_STORE) begin
						for (int l = 0; l < 8; l++)
							if (e.sel[l])
								mem[e.adr[4:3]][8 * l +: 8] = e.dat.lane[l];
					end else begin
						ld_pend = 1'b1;
						ld_exp = shift_extend(mem[e.adr[4:3]], e.adr[2:0], e.sz, e.func);
						ld_thr = e.thread;
					end
				end
			end
			start_pend = !bus_req && q.size() > 0 && q[0].v;
			req_prev = bus_req;

			// Port 0 owns the single slot write while port 1 joins it only with a forward
			room = (q.size() < DEPTH) || pop_m;
			mrg0 = merge_ok(func0, adr0, thread0, nc0);
			mrg1 = merge_ok(func1, adr1, thread1, nc1);
			acc0 = req0 && !hit0 && (mrg0 || room);
			ack0 = req0 && (hit0 || acc0);
			acc1 = req1 && !hit1 && !ack0 && (mrg1 || room);
			ack1 = req1 && (hit1 || acc1);
			exp_ack0 = ack0;
			exp_ack1 = ack1;
			n_acked += int'(ack0) + int'(ack1);

			// Rollback hits the queued entries only and comes before the pop and the write
			for (int i = 0; i < q.size(); i++)
				if (rollback[q[i].thread])
					q[i].v = 1'b0;
			if (pop_m && q.size() > 0)
				void'(q.pop_front());
			if (acc0 || acc1) begin
				if (acc1)
					e = make_entry(func1, sz1, adr1, dat1, thread1, nc1);
				else
					e = make_entry(func0, sz0, adr0, dat0, thread0, nc0);
				if (acc1 ? mrg1 : mrg0) begin
					fd0 = q[$].dat.word;
					for (int l = 0; l < 8; l++)
						if (e.sel[l])
							fd0[8 * l +: 8] = e.dat.lane[l];
					e.dat.word = fd0;
					e.sel = e.sel | q[$].sel;
					e.func = q[$].func;
					e.sz = q[$].sz;
					e.adr = q[$].adr;
					q[$] = e;
				end else begin
					q.push_back(e);
				end
			end

			// New requests once the previous one is acknowledged
			r = $random(seed);
			if (!wr0 || wr_ack0) begin
				if (n_issued < NREQ && r[1:0] != 2'd0) begin
					random_request(f, s, a, d, t, n);
					wr0 <= 1'b1;
					func0 <= f;
					sz0 <= s;
					adr0 <= a;
					dat0 <= d;
					thread0 <= t;
					nc0 <= n;
					n_issued++;
				end else begin
					wr0 <= 1'b0;
				end
			end
			if (!wr1 || wr_ack1) begin
				if (n_issued < NREQ && r[3:2] != 2'd0) begin
					random_request(f, s, a, d, t, n);
					wr1 <= 1'b1;
					func1 <= f;
					sz1 <= s;
					adr1 <= a;
					dat1 <= d;
					thread1 <= t;
					nc1 <= n;
					n_issued++;
				end else begin
					wr1 <= 1'b0;
				end
			end
			// About one rollback pulse in forty cycles on a single thread
			rollback <= (r[15:4] % 40 == 0) ? NT'(1) << r[17:16] : '0;

			// Bus memory answers after zero to three extra cycles
			if (bus_req && bus_ack) begin
				bus_ack <= 1'b0;
				lat = $unsigned($random(seed)) % 4;
			end else if (bus_req) begin
				if (lat == 0) begin
					bus_ack <= 1'b1;
					bus_rdat <= mem[bus_adr[4:3]];
				end else begin
					lat--;
				end
			end
		end
	end

	// ============================================================
	// Run control
	// ============================================================

	initial begin
		logic [31:0] a;
		clk = 1'b0;
		rst = 1'b1;
		{wr0, wr1, nc0, nc1, bus_ack} = '0;
		func0 = MQ_LOAD;
		func1 = MQ_LOAD;
		sz0 = SZ_BYTE;
		sz1 = SZ_BYTE;
		{adr0, adr1, dat0, dat1, thread0, thread1, rollback, bus_rdat} = '0;
		{exp_ack0, exp_ack1, ld_pend, start_pend, req_prev} = '0;
		{err_val, err_proto, n_issued, n_acked, lat} = '0;
		for (int i = 0; i < 4; i++) begin
			a = 32'(BASE) + 32'(i * 8);
			mem[i] = {a ^ 32'h5a5a_c3c3, ~a};
		end
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		wait (n_acked >= NREQ);
		while (!(empty && !bus_req && q.size() == 0 && !wr0 && !wr1))
			@(posedge clk);
		repeat (4) @(posedge clk);
		$display("errors: %0d value, %0d protocol, %0d requests", err_val, err_proto, n_acked);
		if (err_val + err_proto == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	// Twenty cycles per request is far beyond the slowest drain
	initial begin
		#(NREQ * 20 * PERIOD);
		$display("watchdog expired with %0d of %0d requests acknowledged", n_acked, NREQ);
		$display(">>> FAIL");
		$finish;
	end

endmodule

// File: common/memq_config.svh
// Build-time sizes of the memory request queue, included by every file that needs them
`ifndef MEMQ_CONFIG_SVH
`define MEMQ_CONFIG_SVH

// ============================================================
// Queue geometry
// ============================================================

// Number of queue entries, the drain pops from entry zero
`define MEMQ_DEPTH 8

// Hardware threads that share the queue
// The entry thread field is two bits wide, so this stays at four or below
`define MEMQ_NTHREADS 4

// ============================================================
// Address
// ============================================================

// Byte address width of a request, bits [2:0] pick the lane
`define MEMQ_AWID 32

`endif

// File: common/memq_pkg.sv
// Request types, queue entry layout and load extension shared by the queue, drain and testbench
`include "memq_config.svh"

package memq_pkg;

	// Kind of request, the two loads differ only in how the result is extended
	typedef enum logic [1:0] {
		MQ_LOAD  = 2'd0,
		MQ_LOADZ = 2'd1,
		MQ_STORE = 2'd2
	} memq_func_t;

	// Access size, a request never crosses a doubleword
	typedef enum logic [1:0] {
		SZ_BYTE  = 2'd0,
		SZ_WYDE  = 2'd1,
		SZ_TETRA = 2'd2,
		SZ_OCTA  = 2'd3
	} memq_size_t;

	// One doubleword seen either lane by lane or as a whole word
	typedef union packed {
		logic [7:0][7:0] lane;
		logic [63:0]     word;
	} memq_data_u;

	// A queued request with its select and data already moved to lane position
	typedef struct packed {
		memq_func_t            func;
		memq_size_t            sz;
		logic [`MEMQ_AWID-1:0] adr;
		logic [7:0]            sel;
		memq_data_u            dat;
		logic [1:0]            thread;
		logic                  nc;
		logic                  v;
	} memq_entry_t;

	// Brings lane-aligned data down to bit zero and extends it from the access size
	function automatic logic [63:0] memq_extend(
		input memq_data_u d,
		input logic [2:0] adr,
		input memq_size_t sz,
		input memq_func_t func
	);
		logic [63:0] w;
		logic        sx;
		w = d.word >> {adr, 3'b000};
		// Only the plain load copies the sign bit
		sx = (func == MQ_LOAD);
		case (sz)
		SZ_BYTE:  memq_extend = {{56{sx & w[7]}}, w[7:0]};
		SZ_WYDE:  memq_extend = {{48{sx & w[15]}}, w[15:0]};
		SZ_TETRA: memq_extend = {{32{sx & w[31]}}, w[31:0]};
		default:  memq_extend = w;
		endcase
	endfunction

endpackage

// File: mem_req_queue/load_forward.sv
// Store-to-load forwarding search for one request port against the whole queue
`include "memq_config.svh"

module load_forward
	import memq_pkg::*;
(
	input  memq_func_t            func,
	input  memq_size_t            sz,
	input  logic [`MEMQ_AWID-1:0] adr,
	input  logic [7:0]            sel,
	input  logic [1:0]            thread,
	input  logic                  nc,
	input  memq_entry_t           que [`MEMQ_DEPTH],
	input  logic [`MEMQ_DEPTH-1:0] valid_bits,
	output logic                  found,
	output logic [63:0]           fwd_dat
);

	localparam int DEPTH = `MEMQ_DEPTH;
	localparam int AW = `MEMQ_AWID;

	// Entries that are live cacheable stores to the load's doubleword
	logic [DEPTH-1:0] cand;
	// Youngest candidate and whether there was one at all
	logic             hit;
	memq_entry_t      src;
	// Candidate data with lanes outside the load cleared
	memq_data_u       masked;

	// ============================================================
	// Candidate search
	// ============================================================

	// Slots past the fill level may hold stale entries that valid_bits keeps out
	always_comb begin
		for (int i = 0; i < DEPTH; i++) begin
			cand[i] = valid_bits[i] && que[i].v && (que[i].func == MQ_STORE) &&
				!que[i].nc && (que[i].adr[AW-1:3] == adr[AW-1:3]);
		end
	end

	// Higher index means younger, so the last candidate seen wins
	// A younger store that only partly covers the load hides the older ones
	always_comb begin
		hit = 1'b0;
		src = que[0];
		for (int i = 0; i < DEPTH; i++) begin
			if (cand[i]) begin
				hit = 1'b1;
				src = que[i];
			end
		end
	end

	// ============================================================
	// Result
	// ============================================================

	// Every byte of the load has to come from the one store
	// Stores and non-cacheable loads always go to the bus
	always_comb begin
		found = hit && (func != MQ_STORE) && !nc && ((src.sel & sel) == sel);
	end

	// Keep only the load's lanes, then shift down and extend
	always_comb begin
		for (int l = 0; l < 8; l++) begin
			masked.lane[l] = sel[l] ? src.dat.lane[l] : 8'h00;
		end
		fwd_dat = memq_extend(masked, adr[2:0], sz, func);
	end

	// The queue fills from entry zero upward and never leaves a hole below the fill level
	always_comb begin
		assert final ($isunknown(valid_bits) || ((valid_bits & (valid_bits + 1'b1)) == '0))
			else $error("fill mask %b has a gap at a lookup for thread %0d",
				valid_bits, thread);
	end

endmodule

// File: mem_req_queue/mem_req_queue.sv
// Two-port in-order memory request queue with forwarding, store merge, pop and rollback
`include "memq_config.svh"

module mem_req_queue
	import memq_pkg::*;
(
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      wr0,
	input  memq_func_t                func0,
	input  memq_size_t                sz0,
	input  logic [`MEMQ_AWID-1:0]     adr0,
	input  logic [63:0]               dat0,
	input  logic [1:0]                thread0,
	input  logic                      nc0,
	output logic                      wr_ack0,
	output logic                      found0,
	output logic [63:0]               fwd_dat0,
	input  logic                      wr1,
	input  memq_func_t                func1,
	input  memq_size_t                sz1,
	input  logic [`MEMQ_AWID-1:0]     adr1,
	input  logic [63:0]               dat1,
	input  logic [1:0]                thread1,
	input  logic                      nc1,
	output logic                      wr_ack1,
	output logic                      found1,
	output logic [63:0]               fwd_dat1,
	input  logic [`MEMQ_NTHREADS-1:0] rollback,
	input  logic                      pop,
	output memq_entry_t               head,
	output logic                      head_valid,
	output logic                      empty,
	output logic                      full
);

	localparam int DEPTH = `MEMQ_DEPTH;
	localparam int AW = `MEMQ_AWID;
	localparam int CW = $clog2(DEPTH) + 1;

	// Queue storage, entry zero is the head
	memq_entry_t      que [DEPTH];
	memq_entry_t      que_nxt [DEPTH];
	logic [CW-1:0]    count;
	logic [CW-1:0]    count_nxt;
	logic [DEPTH-1:0] valid_bits;

	// Aligned request fields and raw forward hits of both ports
	logic [7:0]       sel0_a;
	logic [7:0]       sel1_a;
	memq_data_u       dat0_a;
	memq_data_u       dat1_a;
	logic             hit0;
	logic             hit1;

	// Acceptance control
	logic             req0;
	logic             req1;
	logic             merge0;
	logic             merge1;
	logic             acc0;
	logic             acc1;
	logic             ack0_nxt;
	logic             pop_ok;
	logic             room;
	logic             slot_wr;
	logic             w_merge;
	logic             tail_ok;
	logic [CW-1:0]    last;
	logic [CW-1:0]    widx;
	logic [CW-1:0]    midx;
	memq_entry_t      youngest;
	memq_entry_t      ent_new;
	memq_entry_t      ent_mrg;

	// ============================================================
	// Per-port alignment and forwarding
	// ============================================================

	req_align ualign0 (.sz(sz0), .adr(adr0[2:0]), .dat(dat0), .sel(sel0_a), .dat_aligned(dat0_a));
	req_align ualign1 (.sz(sz1), .adr(adr1[2:0]), .dat(dat1), .sel(sel1_a), .dat_aligned(dat1_a));

	load_forward ufwd0 (
		.func(func0), .sz(sz0), .adr(adr0), .sel(sel0_a), .thread(thread0), .nc(nc0),
		.que(que), .valid_bits(valid_bits), .found(hit0), .fwd_dat(fwd_dat0)
	);
	load_forward ufwd1 (
		.func(func1), .sz(sz1), .adr(adr1), .sel(sel1_a), .thread(thread1), .nc(nc1),
		.que(que), .valid_bits(valid_bits), .found(hit1), .fwd_dat(fwd_dat1)
	);

	// ============================================================
	// Acceptance
	// ============================================================

	// The requester still holds wr during its ack cycle, that cycle is not a new request
	assign req0 = wr0 && !wr_ack0;
	assign req1 = wr1 && !wr_ack1;
	assign found0 = req0 && hit0;
	assign found1 = req1 && hit1;

	assign pop_ok = pop && !empty;
	// A pop on the same edge frees the slot the write needs
	assign room = !full || pop_ok;
	assign last = count - 1'b1;

	// The head may already be on the bus, so the merge target is entry one or later
	// A target about to be rolled back is skipped and the store takes a new slot
	always_comb begin
		youngest = que[last[CW-2:0]];
		tail_ok = (count >= CW'(2)) && youngest.v && (youngest.func == MQ_STORE) &&
			!youngest.nc && !rollback[youngest.thread];
		merge0 = tail_ok && (func0 == MQ_STORE) && !nc0 && (thread0 == youngest.thread) &&
			(adr0[AW-1:3] == youngest.adr[AW-1:3]);
		merge1 = tail_ok && (func1 == MQ_STORE) && !nc1 && (thread1 == youngest.thread) &&
			(adr1[AW-1:3] == youngest.adr[AW-1:3]);
	end

	// Port 0 gets the single slot write first
	// Port 1 shares the cycle with an acked port 0 only through forwarding
	always_comb begin
		acc0 = req0 && !hit0 && (merge0 || room);
		ack0_nxt = req0 && (hit0 || acc0);
		acc1 = req1 && !hit1 && !ack0_nxt && (merge1 || room);
		slot_wr = acc0 || acc1;
		w_merge = acc1 ? merge1 : merge0;
	end

	// Entry built from whichever port owns the slot write
	always_comb begin
		ent_new.func = acc1 ? func1 : func0;
		ent_new.sz = acc1 ? sz1 : sz0;
		ent_new.adr = acc1 ? adr1 : adr0;
		ent_new.sel = acc1 ? sel1_a : sel0_a;
		ent_new.dat = acc1 ? dat1_a : dat0_a;
		ent_new.thread = acc1 ? thread1 : thread0;
		ent_new.nc = acc1 ? nc1 : nc0;
		ent_new.v = 1'b1;
	end

	// Newer store lanes replace the queued ones, the selects accumulate
	always_comb begin
		ent_mrg = youngest;
		ent_mrg.sel = youngest.sel | ent_new.sel;
		for (int l = 0; l < 8; l++) begin
			if (ent_new.sel[l])
				ent_mrg.dat.lane[l] = ent_new.dat.lane[l];
		end
	end

	// ============================================================
	// Next queue state
	// ============================================================

	// Both targets move down one place when the head leaves on the same edge
	assign widx = pop_ok ? last : count;
	assign midx = pop_ok ? last - 1'b1 : last;

	// Rollback first, then the shift, then the write so the new entry stays live
	always_comb begin
		for (int i = 0; i < DEPTH; i++) begin
			que_nxt[i] = que[i];
			if (rollback[que[i].thread])
				que_nxt[i].v = 1'b0;
		end
		if (pop_ok) begin
			for (int i = 0; i < DEPTH - 1; i++)
				que_nxt[i] = que_nxt[i + 1];
		end
		if (slot_wr) begin
			if (w_merge)
				que_nxt[midx[CW-2:0]] = ent_mrg;
			else
				que_nxt[widx[CW-2:0]] = ent_new;
		end
	end

	assign count_nxt = count + CW'(slot_wr && !w_merge) - CW'(pop_ok);

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			count <= '0;
			wr_ack0 <= 1'b0;
			wr_ack1 <= 1'b0;
		end else begin
			count <= count_nxt;
			wr_ack0 <= ack0_nxt;
			wr_ack1 <= req1 && (hit1 || acc1);
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < DEPTH; i++)
			que[i] <= que_nxt[i];
	end

	// Fill level decodes
	always_comb begin
		for (int i = 0; i < DEPTH; i++)
			valid_bits[i] = (CW'(i) < count);
	end
	assign empty = (count == '0);
	assign full = (count == CW'(DEPTH));
	assign head = que[0];
	assign head_valid = !empty;

	// ============================================================
	// Checks
	// ============================================================

	// The drain only pops what it has been shown
	a_pop_nonempty: assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
		else $error("pop while the queue is empty");
	a_count_range: assert property (@(posedge clk) disable iff (rst) count <= CW'(DEPTH))
		else $error("fill level %0d over depth", count);
	// Each request is acknowledged once even though wr stays up through the ack
	a_ack0_pulse: assert property (@(posedge clk) disable iff (rst) wr_ack0 |=> !wr_ack0);
	a_ack1_pulse: assert property (@(posedge clk) disable iff (rst) wr_ack1 |=> !wr_ack1);

endmodule

// File: mem_req_queue/req_align.sv
// Lane select and data alignment of one request port, instantiated once per port by the queue
module req_align
	import memq_pkg::*;
(
	input  memq_size_t  sz,
	input  logic [2:0]  adr,
	input  logic [63:0] dat,
	output logic [7:0]  sel,
	output memq_data_u  dat_aligned
);

	// Select before it is moved to the addressed lane
	logic [7:0] sel_base;

	// ============================================================
	// Size decode
	// ============================================================

	// One, two, four or eight low lanes depending on the access size
	always_comb begin
		case (sz)
		SZ_BYTE:  sel_base = 8'h01;
		SZ_WYDE:  sel_base = 8'h03;
		SZ_TETRA: sel_base = 8'h0f;
		default:  sel_base = 8'hff;
		endcase
	end

	// ============================================================
	// Lane shift
	// ============================================================

	// Aligned requests never cross the doubleword, so nothing falls off the top
	// The store data arrives right-justified and moves up by whole bytes
	always_comb begin
		sel = sel_base << adr;
		dat_aligned.word = dat << {adr, 3'b000};
	end

endmodule

// File: sources.f
+incdir+common
common/memq_pkg.sv
mem_req_queue/req_align.sv
mem_req_queue/load_forward.sv
mem_req_queue/mem_req_queue.sv
verilog/mem_drain.sv
verilog/mem_req_top.sv
bench/mem_req_tb.sv

// File: verilog/mem_drain.sv
// Drains the queue head onto the request/acknowledge bus and returns extended load data
`include "memq_config.svh"

module mem_drain
	import memq_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst,
	input  memq_entry_t           head,
	input  logic                  head_valid,
	output logic                  pop,
	output logic                  bus_req,
	output logic                  bus_we,
	output logic [`MEMQ_AWID-1:0] bus_adr,
	output logic [7:0]            bus_sel,
	output logic [63:0]           bus_dat,
	input  logic                  bus_ack,
	input  logic [63:0]           bus_rdat,
	output logic                  ld_done,
	output logic [63:0]           ld_dat,
	output logic [1:0]            ld_thread
);

	// High from the start of a transaction up to its acknowledge
	logic       busy;
	logic       start;
	logic       finish;
	// Fields of the entry on the bus that the load result still needs
	memq_func_t cur_func;
	memq_size_t cur_sz;
	logic [1:0] cur_thread;

	assign start = !busy && head_valid && head.v;
	assign finish = busy && bus_ack;
	assign bus_req = busy;

	// Rolled-back entries leave one per cycle without touching the bus
	assign pop = busy ? bus_ack : (head_valid && !head.v);

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			busy <= 1'b0;
			ld_done <= 1'b0;
		end else begin
			ld_done <= finish && !bus_we;
			if (start)
				busy <= 1'b1;
			else if (finish)
				busy <= 1'b0;
		end
	end

	// Bus fields are captured once and held, the head can change under a pending request
	always_ff @(posedge clk) begin
		if (start) begin
			bus_we <= (head.func == MQ_STORE);
			bus_adr <= head.adr;
			bus_sel <= head.sel;
			bus_dat <= head.dat.word;
			cur_func <= head.func;
			cur_sz <= head.sz;
			cur_thread <= head.thread;
		end
		if (finish) begin
			ld_dat <= memq_extend(bus_rdat, bus_adr[2:0], cur_sz, cur_func);
			ld_thread <= cur_thread;
		end
	end

	a_bus_hold: assert property (@(posedge clk) disable iff (rst)
		bus_req && !bus_ack |=> bus_req && $stable(bus_we) && $stable(bus_adr) &&
			$stable(bus_sel) && $stable(bus_dat))
		else $error("bus fields changed before the acknowledge");

endmodule

// File: verilog/mem_req_top.sv
// Top level of the memory request path, two issue ports through the queue to the external bus
`include "memq_config.svh"

module mem_req_top
	import memq_pkg::*;
(
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      wr0,
	input  memq_func_t                func0,
	input  memq_size_t                sz0,
	input  logic [`MEMQ_AWID-1:0]     adr0,
	input  logic [63:0]               dat0,
	input  logic [1:0]                thread0,
	input  logic                      nc0,
	output logic                      wr_ack0,
	output logic                      found0,
	output logic [63:0]               fwd_dat0,
	input  logic                      wr1,
	input  memq_func_t                func1,
	input  memq_size_t                sz1,
	input  logic [`MEMQ_AWID-1:0]     adr1,
	input  logic [63:0]               dat1,
	input  logic [1:0]                thread1,
	input  logic                      nc1,
	output logic                      wr_ack1,
	output logic                      found1,
	output logic [63:0]               fwd_dat1,
	input  logic [`MEMQ_NTHREADS-1:0] rollback,
	output logic                      empty,
	output logic                      full,
	output logic                      bus_req,
	output logic                      bus_we,
	output logic [`MEMQ_AWID-1:0]     bus_adr,
	output logic [7:0]                bus_sel,
	output logic [63:0]               bus_dat,
	input  logic                      bus_ack,
	input  logic [63:0]               bus_rdat,
	output logic                      ld_done,
	output logic [63:0]               ld_dat,
	output logic [1:0]                ld_thread
);

	// Head hand-off between the queue and the drain
	memq_entry_t head;
	logic        head_valid;
	logic        pop;

	// All port names line up one to one with the two blocks
	mem_req_queue uq0 (.*);

	mem_drain udr0 (.*);

endmodule
